// File: tb/fbuf_trace.txt
# C op idx addr_hex   with op 0 set base, 1 enable, 2 disable
# F w r0 r1 w_v w_i r0_v r0_i r1_v r1_i   pulses, then expected grants
# Reset state, pulses ignored while disabled
F 0 0 0 0 0 0 0 0 0
F 1 1 1 0 0 0 0 0 0
# Base table, then enable
C 0 0 10000000
C 0 1 11000000
C 0 2 12000000
C 0 3 13000000
F 1 0 0 0 0 0 0 0 0
C 1 0 00000000
# Writer alone, readers invalid until a frame completes
F 1 0 0 1 0 0 0 0 0
F 0 1 0 1 0 0 0 0 0
F 1 0 0 1 1 0 0 0 0
F 1 0 0 1 0 0 0 0 0
F 0 1 0 1 0 1 1 0 0
F 1 0 0 1 2 1 1 0 0
F 0 0 1 1 2 1 1 1 0
# Readers on 1 and 0, writer on 2, only 3 left
F 1 0 0 1 3 1 1 1 0
# Reader and writer start together
F 1 1 0 1 2 1 3 1 0
F 1 0 0 1 1 1 3 1 0
F 0 0 1 1 1 1 3 1 2
F 1 0 0 1 0 1 3 1 2
F 1 1 1 1 1 1 0 1 0
# Base rewrite under held grants, then disable
C 0 1 21000000
F 0 0 0 1 1 1 0 1 0
C 2 0 00000000
F 1 1 1 1 1 1 0 1 0
C 0 0 20000000
F 0 0 0 1 1 1 0 1 0
C 1 0 00000000
# New grants pick up the rewritten bases
F 0 1 0 1 1 1 0 1 0
F 1 0 0 1 2 1 0 1 0
F 0 0 1 1 2 1 0 1 1
F 1 0 0 1 3 1 0 1 1
F 0 1 1 1 3 1 2 1 2
F 1 0 0 1 0 1 2 1 2
F 1 0 1 1 1 1 2 1 0

// File: sim.f
+incdir+src
src/fbuf_pkg.sv
src/fbuf_cfg_regs.sv
src/fbuf_mutex_ctl.sv
src/fbuf_top.sv
tb/fbuf_assert.sv
tb/fbuf_tb.sv

// File: Makefile
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module fbuf_tb -f sim.f -o fbuf_sim

run: build
	./obj_dir/fbuf_sim | tee sim.log
	grep -q "Finished with no errors" sim.log

lint:
	verilator --lint-only --timing --top-module fbuf_tb -f sim.f

clean:
	rm -rf obj_dir sim.log

// File: tb/fbuf_tb.sv
`timescale 1ns/1ns
`include "fbuf_params.svh"

module fbuf_tb;

	import fbuf_pkg::*;

	// One trace line holds a config command or a frame event
	typedef struct packed {
		logic                    is_cfg;
		logic [1:0]              op;
		logic [IDX_W-1:0]        idx;
		logic [`FBUF_ADDR_W-1:0] addr;
		logic                    w;
		logic                    r0;
		logic                    r1;
		logic                    wv;
		logic [IDX_W-1:0]        wi;
		logic                    r0v;
		logic [IDX_W-1:0]        r0i;
		logic                    r1v;
		logic [IDX_W-1:0]        r1i;
	} trace_ent_t;

	logic       clk;
	logic       resetn;
	logic       cfg_req;
	cfg_req_t   cfg;
	logic       cfg_ack;
	logic       w_sof;
	logic       r0_sof;
	logic       r1_sof;
	buf_grant_t w_grant;
	buf_grant_t r0_grant;
	buf_grant_t r1_grant;

	// Reference model state
	logic [`FBUF_ADDR_W-1:0] base_copy [`FBUF_NUM];
	logic                    en_copy;
	logic [`FBUF_ADDR_W-1:0] exp_w_addr;
	logic [`FBUF_ADDR_W-1:0] exp_r0_addr;
	logic [`FBUF_ADDR_W-1:0] exp_r1_addr;

	trace_ent_t trace_q [$];
	int         cycles = 0;
	int         limit = 0;

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	fbuf_top dut_i (
		.clk      (clk),
		.resetn   (resetn),
		.cfg_req  (cfg_req),
		.cfg      (cfg),
		.cfg_ack  (cfg_ack),
		.w_sof    (w_sof),
		.r0_sof   (r0_sof),
		.r1_sof   (r1_sof),
		.w_grant  (w_grant),
		.r0_grant (r0_grant),
		.r1_grant (r1_grant)
	);

	//////////////////////////////////////////////////
	// Failure reporting
	//////////////////////////////////////////////////

	task automatic fail_stop();
		$display("Finished with errors");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic report_mismatch(input string name, input logic [63:0] exp,
		input logic [63:0] act);
		$display("MISMATCH at %0t: %s expected %0h actual %0h", $time, name, exp, act);
		fail_stop();
	endtask

	task automatic check_grant(input string name, input logic ev,
		input logic [IDX_W-1:0] ei, input logic [`FBUF_ADDR_W-1:0] ea,
		input buf_grant_t g);
		assert (g.valid === ev) else report_mismatch({name, ".valid"}, 64'(ev), 64'(g.valid));
		assert (g.idx === ei) else report_mismatch({name, ".idx"}, 64'(ei), 64'(g.idx));
		assert (g.addr === ea) else report_mismatch({name, ".addr"}, 64'(ea), 64'(g.addr));
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles >= limit) begin
			$display("TIMEOUT: the run did not finish within %0d cycles", limit);
			fail_stop();
		end
	end

	// Concurrent checks in the bound checker
	always @(negedge clk) begin
		assert (dut_i.assert_i.fail_count == 0) else begin
			$display("A bound assertion failed at %0t", $time);
			fail_stop();
		end
	end

	//////////////////////////////////////////////////
	// Trace loading
	//////////////////////////////////////////////////

	task automatic load_trace();
		int                      fd;
		int                      rc;
		logic [7:0]              tok;
		logic [8*200-1:0]        rest;
		int                      fld [9];
		logic [`FBUF_ADDR_W-1:0] addr;
		trace_ent_t              e;
		fd = $fopen("tb/fbuf_trace.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the trace file tb/fbuf_trace.txt");
			fail_stop();
		end
		while (!$feof(fd)) begin
			rc = $fscanf(fd, "%s", tok);
			if (rc != 1) break;
			e = '0;
			if (tok == "#") begin
				// Skip the rest of a comment line
				rc = $fgets(rest, fd);
			end else if (tok == "C") begin
				rc = $fscanf(fd, "%d %d %h", fld[0], fld[1], addr);
				if (rc != 3) begin
					$display("Malformed config line in the trace file");
					fail_stop();
				end
				e.is_cfg = 1'b1;
				e.op     = fld[0][1:0];
				e.idx    = fld[1][IDX_W-1:0];
				e.addr   = addr;
				trace_q.push_back(e);
			end else if (tok == "F") begin
				rc = $fscanf(fd, "%d %d %d %d %d %d %d %d %d",
					fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6], fld[7], fld[8]);
				if (rc != 9) begin
					$display("Malformed frame line in the trace file");
					fail_stop();
				end
				e.w   = fld[0][0];
				e.r0  = fld[1][0];
				e.r1  = fld[2][0];
				e.wv  = fld[3][0];
				e.wi  = fld[4][IDX_W-1:0];
				e.r0v = fld[5][0];
				e.r0i = fld[6][IDX_W-1:0];
				e.r1v = fld[7][0];
				e.r1i = fld[8][IDX_W-1:0];
				trace_q.push_back(e);
			end else begin
				$display("Unknown line kind in the trace file");
				fail_stop();
			end
		end
		$fclose(fd);
	endtask

	//////////////////////////////////////////////////
	// Configuration and frame drivers
	//////////////////////////////////////////////////

	// Waits up to two cycles for cfg_ack to reach the given level
	task automatic wait_ack(input logic level, input string what);
		int n;
		n = 0;
		while (cfg_ack !== level && n < 2) begin
			@(negedge clk);
			n++;
		end
		assert (cfg_ack === level) else begin
			$display("Handshake error at %0t: cfg_ack did not %s within two cycles",
				$time, what);
			fail_stop();
		end
	endtask

	task automatic send_cfg(input trace_ent_t e);
		@(negedge clk);
		cfg.op   = cfg_op_e'(e.op);
		cfg.idx  = e.idx;
		cfg.addr = e.addr;
		cfg_req  = 1'b1;
		wait_ack(1'b1, "rise");
		cfg_req = 1'b0;
		wait_ack(1'b0, "fall");
		case (cfg_op_e'(e.op))
			OP_SET_BASE: base_copy[e.idx] = e.addr;
			OP_ENABLE:   en_copy = 1'b1;
			OP_DISABLE:  en_copy = 1'b0;
			default:     en_copy = en_copy;
		endcase
	endtask

	task automatic run_frame(input trace_ent_t e);
		@(negedge clk);
		w_sof  = e.w;
		r0_sof = e.r0;
		r1_sof = e.r1;
		@(negedge clk);
		w_sof  = 1'b0;
		r0_sof = 1'b0;
		r1_sof = 1'b0;
		// Address is fixed at grant time and held until the next accepted pulse
		if (en_copy && e.w) exp_w_addr = e.wv ? base_copy[e.wi] : '0;
		if (en_copy && e.r0) exp_r0_addr = e.r0v ? base_copy[e.r0i] : '0;
		if (en_copy && e.r1) exp_r1_addr = e.r1v ? base_copy[e.r1i] : '0;
		check_grant("w_grant", e.wv, e.wi, exp_w_addr, w_grant);
		check_grant("r0_grant", e.r0v, e.r0i, exp_r0_addr, r0_grant);
		check_grant("r1_grant", e.r1v, e.r1i, exp_r1_addr, r1_grant);
	endtask

	//////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////

	initial begin
		resetn      = 1'b0;
		cfg_req     = 1'b0;
		cfg         = '0;
		w_sof       = 1'b0;
		r0_sof      = 1'b0;
		r1_sof      = 1'b0;
		en_copy     = 1'b0;
		exp_w_addr  = '0;
		exp_r0_addr = '0;
		exp_r1_addr = '0;
		for (int i = 0; i < `FBUF_NUM; i++) begin
			base_copy[i] = '0;
		end
		load_trace();
		limit = 20 * trace_q.size();
		repeat (10) @(negedge clk);
		resetn = 1'b1;
		foreach (trace_q[i]) begin
			if (trace_q[i].is_cfg) begin
				send_cfg(trace_q[i]);
			end else begin
				run_frame(trace_q[i]);
			end
		end
		repeat (2) @(negedge clk);
		if (dut_i.assert_i.fail_count == 0) begin
			$display("Finished with no errors");
			$finish;
		end else begin
			$display("A bound assertion failed before the end of the run");
			fail_stop();
		end
	end

endmodule

// File: tb/fbuf_assert.sv
`timescale 1ns/1ns

module fbuf_assert (
	input logic                 clk,
	input logic                 resetn,
	input logic                 cfg_req,
	input logic                 cfg_ack,
	input fbuf_pkg::buf_grant_t w_grant,
	input fbuf_pkg::buf_grant_t r0_grant,
	input fbuf_pkg::buf_grant_t r1_grant
);

	// Number of failed checks
	int fail_count = 0;

	// Handshake comes out of reset idle
	ack_after_reset: assert property (@(posedge clk) !resetn |=> !cfg_ack)
		else begin
			fail_count++;
			$error("cfg_ack high in the cycle after reset");
		end

	ack_needs_req: assert property (@(posedge clk) disable iff (!resetn)
		$rose(cfg_ack) |-> $past(cfg_req))
		else begin
			fail_count++;
			$error("cfg_ack rose without cfg_req");
		end

	// Writer never shares a buffer with a reader
	w_r0_exclusive: assert property (@(posedge clk) disable iff (!resetn)
		(w_grant.valid && r0_grant.valid) |-> (w_grant.idx != r0_grant.idx))
		else begin
			fail_count++;
			$error("writer and reader 0 hold the same buffer");
		end

	w_r1_exclusive: assert property (@(posedge clk) disable iff (!resetn)
		(w_grant.valid && r1_grant.valid) |-> (w_grant.idx != r1_grant.idx))
		else begin
			fail_count++;
			$error("writer and reader 1 hold the same buffer");
		end

endmodule

bind fbuf_top fbuf_assert assert_i (
	.clk      (clk),
	.resetn   (resetn),
	.cfg_req  (cfg_req),
	.cfg_ack  (cfg_ack),
	.w_grant  (w_grant),
	.r0_grant (r0_grant),
	.r1_grant (r1_grant)
);

// File: src/fbuf_top.sv
`timescale 1ns/1ns

module fbuf_top (
	input  logic                 clk,
	input  logic                 resetn,

	// Configuration port
	input  logic                 cfg_req,
	input  fbuf_pkg::cfg_req_t   cfg,
	output logic                 cfg_ack,

	// Frame ports
	input  logic                 w_sof,
	input  logic                 r0_sof,
	input  logic                 r1_sof,
	output fbuf_pkg::buf_grant_t w_grant,
	output fbuf_pkg::buf_grant_t r0_grant,
	output fbuf_pkg::buf_grant_t r1_grant
);

	import fbuf_pkg::*;

	// Register block to arbiter
	buf_bases_t bases;
	logic       enable;

	fbuf_cfg_regs cfg_regs_i (
		.clk     (clk),
		.resetn  (resetn),
		.cfg_req (cfg_req),
		.cfg     (cfg),
		.cfg_ack (cfg_ack),
		.bases   (bases),
		.enable  (enable)
	);

	fbuf_mutex_ctl mutex_ctl_i (
		.clk      (clk),
		.resetn   (resetn),
		.bases    (bases),
		.enable   (enable),
		.w_sof    (w_sof),
		.r0_sof   (r0_sof),
		.r1_sof   (r1_sof),
		.w_grant  (w_grant),
		.r0_grant (r0_grant),
		.r1_grant (r1_grant)
	);

endmodule

// File: src/fbuf_mutex_ctl.sv
`timescale 1ns/1ns
`include "fbuf_params.svh"

module fbuf_mutex_ctl (
	input  logic                 clk,
	input  logic                 resetn,
	input  fbuf_pkg::buf_bases_t bases,
	input  logic                 enable,
	input  logic                 w_sof,
	input  logic                 r0_sof,
	input  logic                 r1_sof,
	output fbuf_pkg::buf_grant_t w_grant,
	output fbuf_pkg::buf_grant_t r0_grant,
	output fbuf_pkg::buf_grant_t r1_grant
);

	import fbuf_pkg::*;

	localparam int NUM_RD = 2;

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	// Index of the set bit in a one-hot map
	function automatic logic [IDX_W-1:0] bmp_to_idx(input logic [`FBUF_NUM-1:0] bmp);
		logic [IDX_W-1:0] idx;
		idx = '0;
		for (int i = 0; i < `FBUF_NUM; i++) begin
			if (bmp[i]) begin
				idx = idx | IDX_W'(i);
			end
		end
		return idx;
	endfunction

	// Grant for a held buffer with its address from the current base table
	function automatic buf_grant_t make_grant(
		input logic [`FBUF_NUM-1:0] bmp,
		input buf_bases_t           tbl
	);
		buf_grant_t       g;
		logic [IDX_W-1:0] idx;
		idx     = bmp_to_idx(bmp);
		g.valid = |bmp;
		g.idx   = idx;
		g.addr  = g.valid ? tbl[idx] : '0;
		return g;
	endfunction

	//////////////////////////////////////////////////
	// Ownership state
	//////////////////////////////////////////////////

	logic [`FBUF_NUM-1:0] w_bmp;
	logic [`FBUF_NUM-1:0] last_bmp;
	logic [`FBUF_NUM-1:0] r_bmp [NUM_RD];
	buf_grant_t           r_grant [NUM_RD];

	// Accepted frame starts
	logic              w_go;
	logic [NUM_RD-1:0] r_go;

	logic [`FBUF_NUM-1:0] held;
	logic [`FBUF_NUM-1:0] next_bmp;
	logic [`FBUF_NUM-1:0] rd_src_bmp;

	assign w_go = enable && w_sof;
	assign r_go = {r1_sof, r0_sof} & {NUM_RD{enable}};

	// The outgoing writer buffer counts as held so a fresh frame is not overwritten
	assign held = w_bmp | r_bmp[0] | r_bmp[1];

	// Scan from the top so the lowest free buffer wins
	always_comb begin
		next_bmp = '0;
		for (int i = `FBUF_NUM - 1; i >= 0; i--) begin
			if (!held[i]) begin
				next_bmp    = '0;
				next_bmp[i] = 1'b1;
			end
		end
	end

	// A reader starting together with the writer gets the frame completing now
	assign rd_src_bmp = w_go ? w_bmp : last_bmp;

	//////////////////////////////////////////////////
	// Writer and last completed buffer
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!resetn) begin
			w_bmp    <= '0;
			last_bmp <= '0;
			w_grant  <= '0;
		end else if (w_go) begin
			last_bmp <= w_bmp;
			w_bmp    <= next_bmp;
			w_grant  <= make_grant(next_bmp, bases);
		end
	end

	//////////////////////////////////////////////////
	// Readers
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!resetn) begin
			for (int n = 0; n < NUM_RD; n++) begin
				r_bmp[n]   <= '0;
				r_grant[n] <= '0;
			end
		end else begin
			for (int n = 0; n < NUM_RD; n++) begin
				if (r_go[n]) begin
					// Invalid source leaves the reader holding nothing
					r_bmp[n]   <= rd_src_bmp;
					r_grant[n] <= make_grant(rd_src_bmp, bases);
				end
			end
		end
	end

	assign r0_grant = r_grant[0];
	assign r1_grant = r_grant[1];

endmodule

// File: src/fbuf_cfg_regs.sv
`timescale 1ns/1ns

module fbuf_cfg_regs (
	input  logic                clk,
	input  logic                resetn,
	input  logic                cfg_req,
	input  fbuf_pkg::cfg_req_t  cfg,
	output logic                cfg_ack,
	output fbuf_pkg::buf_bases_t bases,
	output logic                enable
);

	import fbuf_pkg::*;

	hs_state_e state;
	hs_state_e state_next;

	// High for the single cycle in which a new request is taken
	logic apply;

	// Decoded opcode strobes
	logic do_set_base;
	logic do_enable;
	logic do_disable;

	//////////////////////////////////////////////////
	// Four-phase handshake
	//////////////////////////////////////////////////

	// A request is taken only from idle, so each req pulse applies once
	assign apply = (state == HS_IDLE) && cfg_req;

	always_comb begin
		state_next = state;
		case (state)
			HS_IDLE: begin
				if (cfg_req) begin
					state_next = HS_ACK;
				end
			end
			HS_ACK: begin
				// Hold ack until the requester drops req
				if (!cfg_req) begin
					state_next = HS_IDLE;
				end
			end
			default: begin
				state_next = HS_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= HS_IDLE;
		end else begin
			state <= state_next;
		end
	end

	// Ack rises one cycle after req is seen high, falls one after it is seen low
	assign cfg_ack = (state == HS_ACK);

	//////////////////////////////////////////////////
	// Opcode decode and register updates
	//////////////////////////////////////////////////

	assign do_set_base = apply && (cfg.op == OP_SET_BASE);
	assign do_enable   = apply && (cfg.op == OP_ENABLE);
	assign do_disable  = apply && (cfg.op == OP_DISABLE);

	// One base table entry written per request
	always_ff @(posedge clk) begin
		if (!resetn) begin
			bases <= '0;
		end else if (do_set_base) begin
			bases[cfg.idx] <= cfg.addr;
		end
	end

	// Frame start gating for the arbiter
	always_ff @(posedge clk) begin
		if (!resetn) begin
			enable <= 1'b0;
		end else if (do_enable) begin
			enable <= 1'b1;
		end else if (do_disable) begin
			enable <= 1'b0;
		end
	end

endmodule

// File: src/fbuf_pkg.sv
`include "fbuf_params.svh"

package fbuf_pkg;

	// Bits needed to name one buffer
	localparam int IDX_W = $clog2(`FBUF_NUM);

	//////////////////////////////////////////////////
	// Configuration port
	//////////////////////////////////////////////////

	typedef enum logic [1:0] {
		OP_SET_BASE = 2'd0,
		OP_ENABLE   = 2'd1,
		OP_DISABLE  = 2'd2
	} cfg_op_e;

	// Ack mirrors the handshake state
	typedef enum logic {
		HS_IDLE = 1'b0,
		HS_ACK  = 1'b1
	} hs_state_e;

	typedef struct packed {
		cfg_op_e                 op;
		logic [IDX_W-1:0]        idx;
		logic [`FBUF_ADDR_W-1:0] addr;
	} cfg_req_t;

	//////////////////////////////////////////////////
	// Buffer grants and base table
	//////////////////////////////////////////////////

	// Same shape for the writer and both readers
	typedef struct packed {
		logic                    valid;
		logic [IDX_W-1:0]        idx;
		logic [`FBUF_ADDR_W-1:0] addr;
	} buf_grant_t;

	// Entry n is the base address of buffer n
	typedef logic [`FBUF_NUM-1:0][`FBUF_ADDR_W-1:0] buf_bases_t;

endpackage

// File: src/fbuf_params.svh
`ifndef FBUF_PARAMS_SVH
`define FBUF_PARAMS_SVH

// Width of a buffer base address
`define FBUF_ADDR_W 32

// Two readers plus one writer plus one spare
`define FBUF_NUM 4

`endif
